/* hdl/gpio_pad_ctrl.sv */
`timescale 1ns/1ps

module gpio_pad_ctrl (
    input  logic                               clk,
    input  logic                               rst_n_i,

    input  logic [gpio_pkg::PINS_PER_BANK-1:0] gpio_in_i,  // raw pad inputs

    input  logic [gpio_pkg::PINS_PER_BANK-1:0] opt_i,      // output data reg
    input  logic [gpio_pkg::PINS_PER_BANK-1:0] oec_i,      // output enable reg
    input  logic [gpio_pkg::PINS_PER_BANK-1:0] omd_i,      // output mode reg

    output logic [gpio_pkg::PINS_PER_BANK-1:0] din_sync_o, // to input register

    output logic [gpio_pkg::PINS_PER_BANK-1:0] gpio_oe_o,  // pad drive enable
    output logic [gpio_pkg::PINS_PER_BANK-1:0] gpio_out_o  // pad drive value
);

    localparam int PINS = gpio_pkg::PINS_PER_BANK;

    logic [PINS-1:0] sync1_q; // first flop, may go metastable
    logic [PINS-1:0] sync2_q; // settled copy

    gpio_pkg::pin_mode_e pin_mode [PINS];

    // two flop synchronizer on every pin
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
        end
    end

    assign din_sync_o = sync2_q;

    // mode decode, straight from the registers
    always_comb begin
        for (int i = 0; i < PINS; i++) begin
            pin_mode[i] = gpio_pkg::pin_mode_e'({oec_i[i], omd_i[i]});
            case (pin_mode[i])
                gpio_pkg::MODE_IN,
                gpio_pkg::MODE_IN_LATCH: begin
                    gpio_oe_o[i]  = 1'b0; // pad floats
                    gpio_out_o[i] = 1'b0;
                end
                gpio_pkg::MODE_PUSH_PULL: begin
                    gpio_oe_o[i]  = 1'b1;
                    gpio_out_o[i] = opt_i[i];
                end
                gpio_pkg::MODE_OPEN_DRAIN: begin
                    gpio_oe_o[i]  = ~opt_i[i]; // drive only the low level
                    gpio_out_o[i] = 1'b0;
                end
                default: begin
                    gpio_oe_o[i]  = 1'b0;
                    gpio_out_o[i] = 1'b0;
                end
            endcase
        end
    end

    // input-mode pins never present a value to the pad
    a_out_quiet : assert property (
        @(posedge clk) disable iff (!rst_n_i) (gpio_out_o & ~oec_i) == '0
    ) else $error("pad value driven on a pin with output enable clear");

endmodule

/* hdl/gpio_pkg.sv */
package gpio_pkg;

    parameter int PINS_PER_BANK = 32;

    // register offsets inside one bank, word aligned
    typedef enum logic [periph_bus_pkg::OFFS_W-1:0] {
        REG_DIN = 8'h00, // input data, read only
        REG_OPT = 8'h04, // output data
        REG_OEC = 8'h08, // output enable
        REG_OMD = 8'h0C  // output mode
    } gpio_reg_e;

    // per-pin mode, code is {oec bit, omd bit}
    typedef enum logic [1:0] {
        MODE_IN         = 2'b00, // hi-z input
        MODE_IN_LATCH   = 2'b01, // hi-z input, value frozen
        MODE_PUSH_PULL  = 2'b10, // drive opt both ways
        MODE_OPEN_DRAIN = 2'b11  // only pull low
    } pin_mode_e;

    // register reset values
    parameter logic [PINS_PER_BANK-1:0] OPT_RESET = '1; // idle high
    parameter logic [PINS_PER_BANK-1:0] OEC_RESET = '0; // all pins input
    parameter logic [PINS_PER_BANK-1:0] OMD_RESET = '0;

endpackage

/* hdl/gpio_regs.sv */
`timescale 1ns/1ps

module gpio_regs (
    input  logic                                      clk,
    input  logic                                      rst_n_i,

    input  logic [periph_bus_pkg::OFFS_W-1:0]         waddr_i, // offset inside bank
    input  logic [periph_bus_pkg::OFFS_W-1:0]         raddr_i,
    input  periph_bus_pkg::data_t                     wdata_i,
    input  logic [periph_bus_pkg::SEL_W-1:0]          sel_i,
    input  logic                                      we_i,    // bank write strobe
    input  logic                                      rd_i,    // bank read strobe
    output periph_bus_pkg::data_t                     rdata_o,

    input  logic [gpio_pkg::PINS_PER_BANK-1:0]        din_sync_i, // from synchronizer
    output logic [gpio_pkg::PINS_PER_BANK-1:0]        opt_o,
    output logic [gpio_pkg::PINS_PER_BANK-1:0]        oec_o,
    output logic [gpio_pkg::PINS_PER_BANK-1:0]        omd_o
);

    localparam int PINS = gpio_pkg::PINS_PER_BANK;

    logic [PINS-1:0] opt_q;  // output data
    logic [PINS-1:0] oec_q;  // output enable
    logic [PINS-1:0] omd_q;  // output mode
    logic [PINS-1:0] din_q;  // input data

    logic [PINS-1:0]       latched_pins; // pins in MODE_IN_LATCH
    periph_bus_pkg::data_t rdata_q;

    gpio_pkg::gpio_reg_e   wreg;
    gpio_pkg::gpio_reg_e   rreg;

    // keep old bytes where the lane select is clear
    function automatic periph_bus_pkg::data_t merge_bytes(
        input periph_bus_pkg::data_t            old_v,
        input periph_bus_pkg::data_t            new_v,
        input logic [periph_bus_pkg::SEL_W-1:0] sel
    );
        periph_bus_pkg::data_t res;
        res = old_v;
        for (int b = 0; b < periph_bus_pkg::SEL_W; b++) begin
            if (sel[b])
                res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    assign wreg = gpio_pkg::gpio_reg_e'(waddr_i);
    assign rreg = gpio_pkg::gpio_reg_e'(raddr_i);

    // write side, byte masked
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            opt_q <= gpio_pkg::OPT_RESET;
            oec_q <= gpio_pkg::OEC_RESET;
            omd_q <= gpio_pkg::OMD_RESET;
        end else if (we_i) begin
            case (wreg)
                gpio_pkg::REG_OPT: opt_q <= merge_bytes(opt_q, wdata_i, sel_i);
                gpio_pkg::REG_OEC: oec_q <= merge_bytes(oec_q, wdata_i, sel_i);
                gpio_pkg::REG_OMD: omd_q <= merge_bytes(omd_q, wdata_i, sel_i);
                default: ; // din is read only, unknown offsets dropped
            endcase
        end
    end

    // which pins hold their last sampled input
    always_comb begin
        for (int i = 0; i < PINS; i++) begin
            latched_pins[i] = (gpio_pkg::pin_mode_e'({oec_q[i], omd_q[i]})
                               == gpio_pkg::MODE_IN_LATCH);
        end
    end

    // input register, third stage after the two sync flops
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            din_q <= '0;
        else
            din_q <= (din_q & latched_pins) | (din_sync_i & ~latched_pins);
    end

    // read port, loads only on the strobe and holds otherwise
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (rd_i) begin
            case (rreg)
                gpio_pkg::REG_DIN: rdata_q <= din_q;
                gpio_pkg::REG_OPT: rdata_q <= opt_q;
                gpio_pkg::REG_OEC: rdata_q <= oec_q;
                gpio_pkg::REG_OMD: rdata_q <= omd_q;
                default:           rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign opt_o   = opt_q;
    assign oec_o   = oec_q;
    assign omd_o   = omd_q;

    // a pin latched before the edge keeps its input value across it
    a_latch_hold : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (|latched_pins) |=> (((din_q ^ $past(din_q)) & $past(latched_pins)) == '0)
    ) else $error("latched input pin changed");

endmodule

/* hdl/gpio_subsys.sv */
`timescale 1ns/1ps

module gpio_subsys #(
    parameter int NUM_BANKS = 2 // 1 to 16
) (
    input  logic                                          clk,
    input  logic                                          rst_n_i,

    input  periph_bus_pkg::addr_t                         waddr_i,
    input  periph_bus_pkg::data_t                         wdata_i,
    input  logic [periph_bus_pkg::SEL_W-1:0]              sel_i,
    input  logic                                          we_i,
    input  periph_bus_pkg::addr_t                         raddr_i,
    input  logic                                          rd_i,
    output periph_bus_pkg::data_t                         rdata_o,

    input  logic [NUM_BANKS*gpio_pkg::PINS_PER_BANK-1:0]  gpio_in_i,
    output logic [NUM_BANKS*gpio_pkg::PINS_PER_BANK-1:0]  gpio_oe_o,
    output logic [NUM_BANKS*gpio_pkg::PINS_PER_BANK-1:0]  gpio_out_o
);

    localparam int PINS = gpio_pkg::PINS_PER_BANK;

    logic                  [NUM_BANKS-1:0] bank_we;    // one-hot write strobe
    logic                  [NUM_BANKS-1:0] bank_rd;    // one-hot read strobe
    periph_bus_pkg::data_t [NUM_BANKS-1:0] bank_rdata; // per bank read port

    periph_bus_decoder #(
        .NUM_BANKS (NUM_BANKS)
    ) u_decoder (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .waddr_i      (waddr_i),
        .raddr_i      (raddr_i),
        .we_i         (we_i),
        .rd_i         (rd_i),
        .bank_we_o    (bank_we),
        .bank_rd_o    (bank_rd),
        .bank_rdata_i (bank_rdata),
        .rdata_o      (rdata_o)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic [PINS-1:0] opt;
        logic [PINS-1:0] oec;
        logic [PINS-1:0] omd;
        logic [PINS-1:0] din_sync;

        gpio_regs u_regs (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .waddr_i    (waddr_i[periph_bus_pkg::OFFS_W-1:0]), // offset byte only
            .raddr_i    (raddr_i[periph_bus_pkg::OFFS_W-1:0]),
            .wdata_i    (wdata_i),
            .sel_i      (sel_i),
            .we_i       (bank_we[b]),
            .rd_i       (bank_rd[b]),
            .rdata_o    (bank_rdata[b]),
            .din_sync_i (din_sync),
            .opt_o      (opt),
            .oec_o      (oec),
            .omd_o      (omd)
        );

        gpio_pad_ctrl u_pad (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .gpio_in_i  (gpio_in_i[b*PINS +: PINS]),
            .opt_i      (opt),
            .oec_i      (oec),
            .omd_i      (omd),
            .din_sync_o (din_sync),
            .gpio_oe_o  (gpio_oe_o[b*PINS +: PINS]),
            .gpio_out_o (gpio_out_o[b*PINS +: PINS])
        );
    end

endmodule

/* hdl/periph_bus_decoder.sv */
`timescale 1ns/1ps

module periph_bus_decoder #(
    parameter int NUM_BANKS = 2
) (
    input  logic                                       clk,
    input  logic                                       rst_n_i,

    input  periph_bus_pkg::addr_t                      waddr_i,
    input  periph_bus_pkg::addr_t                      raddr_i,
    input  logic                                       we_i,
    input  logic                                       rd_i,

    output logic                  [NUM_BANKS-1:0]      bank_we_o,
    output logic                  [NUM_BANKS-1:0]      bank_rd_o,
    input  periph_bus_pkg::data_t [NUM_BANKS-1:0]      bank_rdata_i,

    output periph_bus_pkg::data_t                      rdata_o
);

    localparam int BANK_W = periph_bus_pkg::ADDR_W - periph_bus_pkg::BANK_LSB;

    logic [BANK_W-1:0] wbank;       // bank field of write address
    logic [BANK_W-1:0] rbank;       // bank field of read address
    logic              rd_unmapped; // read aimed past the last bank

    logic [BANK_W-1:0] rd_bank_q;     // bank of the last read
    logic              rd_unmapped_q;

    assign wbank       = waddr_i[periph_bus_pkg::ADDR_W-1:periph_bus_pkg::BANK_LSB];
    assign rbank       = raddr_i[periph_bus_pkg::ADDR_W-1:periph_bus_pkg::BANK_LSB];
    assign rd_unmapped = !(rbank < NUM_BANKS);

    // strobe fan-out, an unmapped bank number matches no index
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_we_o[b] = we_i && (wbank == BANK_W'(b));
            bank_rd_o[b] = rd_i && (rbank == BANK_W'(b));
        end
    end

    // remember where the read went, banks answer one cycle later
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_bank_q     <= '0;
            rd_unmapped_q <= 1'b0;
        end else if (rd_i) begin
            rd_bank_q     <= rbank;
            rd_unmapped_q <= rd_unmapped;
        end
    end

    // return mux over the banks' registered read data
    always_comb begin
        rdata_o = '0; // unmapped reads give zero
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (!rd_unmapped_q && rd_bank_q == BANK_W'(b))
                rdata_o = bank_rdata_i[b];
        end
    end

    // a write never lands in two banks
    a_one_bank_we : assert property (
        @(posedge clk) disable iff (!rst_n_i) $onehot0(bank_we_o)
    ) else $error("more than one bank write strobe");

    // no read strobe, so neither select nor bank data may move
    a_rdata_hold : assert property (
        @(posedge clk) disable iff (!rst_n_i) !rd_i |=> $stable(rdata_o)
    ) else $error("rdata_o changed without a read");

endmodule

/* hdl/periph_bus_pkg.sv */
package periph_bus_pkg;

    // word and address geometry of the peripheral bus
    parameter int DATA_W = 32;       // data word
    parameter int ADDR_W = 12;       // full byte address
    parameter int SEL_W  = DATA_W / 8; // one select per byte lane

    // address split: low byte is the register offset inside a bank,
    // the bits above it pick the bank
    parameter int OFFS_W   = 8;
    parameter int BANK_LSB = 8;      // bank field is addr[11:8]

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

/* project.f */
hdl/periph_bus_pkg.sv
hdl/gpio_pkg.sv
hdl/periph_bus_decoder.sv
hdl/gpio_regs.sv
hdl/gpio_pad_ctrl.sv
hdl/gpio_subsys.sv
sim/tb_clk_gen.sv
sim/gpio_tb.sv

/* sim/gpio_tb.sv */
`timescale 1ns/1ps

module gpio_tb;

    localparam int NB         = 2;  // banks in the DUT
    localparam int PINS       = 32;
    localparam int RST_CYCLES = 5;
    localparam int SEED       = 2;
    localparam int N_RAND     = 200; // random write/read pairs
    // bus operations of all phases, input settles counted as one op each
    localparam int N_OPS      = 8 + 2 * N_RAND + N_RAND / 40 + 40;
    localparam int WDOG_CYCLES = N_OPS * 20 + RST_CYCLES;

    logic                                   clk;
    logic                                   rst_n;
    periph_bus_pkg::addr_t                  waddr_i;
    periph_bus_pkg::data_t                  wdata_i;
    logic [periph_bus_pkg::SEL_W-1:0]       sel_i;
    logic                                   we_i;
    periph_bus_pkg::addr_t                  raddr_i;
    logic                                   rd_i;
    periph_bus_pkg::data_t                  rdata_o;
    logic [NB*PINS-1:0]                     gpio_in_i;
    logic [NB*PINS-1:0]                     gpio_oe_o;
    logic [NB*PINS-1:0]                     gpio_out_o;

    // reference model state, one entry per mapped bank
    logic [PINS-1:0]    opt_m [NB];
    logic [PINS-1:0]    oec_m [NB];
    logic [PINS-1:0]    omd_m [NB];
    logic [PINS-1:0]    din_m [NB];    // value the input register should hold
    logic [NB*PINS-1:0] gin_m;         // settled pad input level

    tb_clk_gen #(
        .PERIOD     (10ns),
        .RST_CYCLES (RST_CYCLES)
    ) u_clk_gen (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    gpio_subsys #(
        .NUM_BANKS (NB)
    ) u_dut (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .waddr_i    (waddr_i),
        .wdata_i    (wdata_i),
        .sel_i      (sel_i),
        .we_i       (we_i),
        .raddr_i    (raddr_i),
        .rd_i       (rd_i),
        .rdata_o    (rdata_o),
        .gpio_in_i  (gpio_in_i),
        .gpio_oe_o  (gpio_oe_o),
        .gpio_out_o (gpio_out_o)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_rdata(input string name, input periph_bus_pkg::data_t exp,
                               input periph_bus_pkg::data_t act);
        if (act !== exp)
            fail_run($sformatf("Mismatch %s: expected 0x%08h, got 0x%08h", name, exp, act));
    endtask

    task automatic check_pins(input logic [NB*PINS-1:0] exp_oe,
                              input logic [NB*PINS-1:0] exp_out);
        if (gpio_oe_o !== exp_oe)
            fail_run($sformatf("Mismatch gpio_oe_o: expected 0x%016h, got 0x%016h",
                               exp_oe, gpio_oe_o));
        if (gpio_out_o !== exp_out)
            fail_run($sformatf("Mismatch gpio_out_o: expected 0x%016h, got 0x%016h",
                               exp_out, gpio_out_o));
    endtask

    // byte lanes with a set select take the new data
    function automatic periph_bus_pkg::data_t lane_merge(input periph_bus_pkg::data_t old_v,
                                                         input periph_bus_pkg::data_t new_v,
                                                         input logic [3:0] sel);
        periph_bus_pkg::data_t mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    // latch mode is oe bit clear, mode bit set
    function automatic logic [PINS-1:0] latch_mask(input int b);
        return ~oec_m[b] & omd_m[b];
    endfunction

    // unlatched pins follow the settled input, latched ones keep their value
    function automatic void refresh_din();
        logic [PINS-1:0] lat;
        for (int b = 0; b < NB; b++) begin
            lat      = latch_mask(b);
            din_m[b] = (din_m[b] & lat) | (gin_m[b*PINS +: PINS] & ~lat);
        end
    endfunction

    function automatic periph_bus_pkg::data_t model_read(input periph_bus_pkg::addr_t a);
        int b;
        b = int'(a[11:8]);
        if (b >= NB)
            return '0; // unmapped bank
        case (a[7:0])
            gpio_pkg::REG_DIN: return din_m[b];
            gpio_pkg::REG_OPT: return opt_m[b];
            gpio_pkg::REG_OEC: return oec_m[b];
            gpio_pkg::REG_OMD: return omd_m[b];
            default:           return '0;
        endcase
    endfunction

    function automatic void model_write(input periph_bus_pkg::addr_t a,
                                        input periph_bus_pkg::data_t d, input logic [3:0] sel);
        int b;
        b = int'(a[11:8]);
        if (b < NB) begin
            case (a[7:0])
                gpio_pkg::REG_OPT: opt_m[b] = lane_merge(opt_m[b], d, sel);
                gpio_pkg::REG_OEC: oec_m[b] = lane_merge(oec_m[b], d, sel);
                gpio_pkg::REG_OMD: omd_m[b] = lane_merge(omd_m[b], d, sel);
                default: ; // din and holes ignore writes
            endcase
        end
        refresh_din();
    endfunction

    // push-pull drives opt, open-drain enables only for a low level
    task automatic expect_pins();
        logic [NB*PINS-1:0] oe;
        logic [NB*PINS-1:0] out;
        logic [PINS-1:0]    pp;
        logic [PINS-1:0]    od;
        for (int b = 0; b < NB; b++) begin
            pp                 = oec_m[b] & ~omd_m[b];
            od                 = oec_m[b] & omd_m[b];
            oe[b*PINS +: PINS]  = pp | (od & ~opt_m[b]);
            out[b*PINS +: PINS] = pp & opt_m[b];
        end
        check_pins(oe, out);
    endtask

    function automatic periph_bus_pkg::addr_t mk_addr(input int bank, input logic [7:0] off);
        return {bank[3:0], off};
    endfunction

    task automatic bus_write(input periph_bus_pkg::addr_t a, input periph_bus_pkg::data_t d,
                             input logic [3:0] sel);
        @(posedge clk);
        waddr_i <= a;
        wdata_i <= d;
        sel_i   <= sel;
        we_i    <= 1'b1;
        @(posedge clk); // DUT takes the write here
        we_i    <= 1'b0;
        model_write(a, d, sel);
        @(negedge clk);
        expect_pins();
    endtask

    task automatic bus_read(input periph_bus_pkg::addr_t a);
        periph_bus_pkg::data_t exp;
        exp = model_read(a);
        @(posedge clk);
        raddr_i <= a;
        rd_i    <= 1'b1;
        @(posedge clk);
        rd_i    <= 1'b0;
        @(negedge clk); // data valid one cycle after the strobe
        check_rdata("rdata_o", exp, rdata_o);
    endtask

    // read and write in one cycle, read must see the old value
    task automatic bus_read_write(input periph_bus_pkg::addr_t a, input periph_bus_pkg::data_t d,
                                  input logic [3:0] sel);
        periph_bus_pkg::data_t exp_old;
        exp_old = model_read(a);
        @(posedge clk);
        waddr_i <= a;
        wdata_i <= d;
        sel_i   <= sel;
        we_i    <= 1'b1;
        raddr_i <= a;
        rd_i    <= 1'b1;
        @(posedge clk);
        we_i    <= 1'b0;
        rd_i    <= 1'b0;
        model_write(a, d, sel);
        @(negedge clk);
        check_rdata("rdata_o", exp_old, rdata_o);
        expect_pins();
    endtask

    // new pad level, then wait out sync flops and input register
    task automatic settle_input(input logic [NB*PINS-1:0] lvl);
        @(posedge clk);
        gpio_in_i <= lvl;
        gin_m = lvl;
        repeat (3) @(posedge clk);
        refresh_din();
    endtask

    function automatic logic [NB*PINS-1:0] rand_pins();
        return {$urandom(), $urandom()};
    endfunction

    initial begin
        waddr_i   <= '0;
        wdata_i   <= '0;
        sel_i     <= '0;
        we_i      <= 1'b0;
        raddr_i   <= '0;
        rd_i      <= 1'b0;
        gpio_in_i <= '0;
    end

    // watchdog, sized from the op count
    initial begin
        #(WDOG_CYCLES * 10ns);
        fail_run("timeout: the test sequence did not complete in time");
    end

    initial begin
        int                    bank;
        int                    r;
        logic [7:0]            off;
        logic [PINS-1:0]       lat_pins;
        periph_bus_pkg::addr_t a;

        r = $urandom(SEED); // seed once
        for (int b = 0; b < NB; b++) begin
            opt_m[b] = '1; // reset values
            oec_m[b] = '0;
            omd_m[b] = '0;
            din_m[b] = '0;
        end
        gin_m = '0;

        @(posedge rst_n);
        @(negedge clk);
        expect_pins(); // all pins input after reset
        check_rdata("rdata_o", '0, rdata_o); // read port cleared by reset

        for (int b = 0; b < NB; b++) begin
            for (int k = 0; k < 4; k++)
                bus_read(mk_addr(b, 8'(4 * k)));
        end

        // random writes, each read back
        settle_input(rand_pins());
        for (int n = 0; n < N_RAND; n++) begin
            if (n % 40 == 39)
                settle_input(rand_pins());
            bank = $urandom_range(0, 3); // 2 and 3 are unmapped
            r    = $urandom_range(0, 7);
            off  = (r < 4) ? 8'(4 * r) : 8'($urandom());
            a    = mk_addr(bank, off);
            bus_write(a, $urandom(), 4'($urandom()));
            bus_read(a);
        end

        // input data register is read only
        for (int b = 0; b < NB; b++) begin
            bus_write(mk_addr(b, 8'h04), 32'h0, 4'hF); // avoid leftover latches below
            bus_write(mk_addr(b, 8'h08), 32'h0, 4'hF);
            bus_write(mk_addr(b, 8'h0C), 32'h0, 4'hF);
        end
        settle_input(rand_pins());
        for (int b = 0; b < NB; b++) begin
            bus_write(mk_addr(b, 8'h00), $urandom(), 4'hF);
            bus_read(mk_addr(b, 8'h00));
        end

        // latch some pins, move the pads, latched pins keep the old level
        for (int b = 0; b < NB; b++) begin
            lat_pins = $urandom();
            bus_write(mk_addr(b, 8'h0C), lat_pins, 4'hF);
        end
        settle_input(rand_pins());
        for (int b = 0; b < NB; b++)
            bus_read(mk_addr(b, 8'h00));
        for (int b = 0; b < NB; b++)
            bus_write(mk_addr(b, 8'h0C), 32'h0, 4'hF); // release
        repeat (3) @(posedge clk);
        for (int b = 0; b < NB; b++)
            bus_read(mk_addr(b, 8'h00));

        // push-pull and open-drain mix on both banks
        for (int b = 0; b < NB; b++) begin
            bus_write(mk_addr(b, 8'h04), $urandom(), 4'hF);
            bus_write(mk_addr(b, 8'h08), $urandom(), 4'hF);
            bus_write(mk_addr(b, 8'h0C), $urandom(), 4'hF);
        end

        // same register read and written in one cycle
        a = mk_addr(1, 8'h04);
        bus_read_write(a, $urandom(), 4'hF);
        bus_read(a);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter realtime PERIOD     = 10ns, // clock period
    parameter int      RST_CYCLES = 5     // reset length in clocks
) (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset low from time zero, released on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n_o <= 1'b1;
    end

endmodule
